// ==== Makefile ====
# Verilator build of the execution slice testbench

VERILATOR ?= verilator
TOP       ?= tb_exec_core
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
SOURCES   := $(wildcard src/*.sv src/*.svh verif/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# A $fatal in the testbench gives a non-zero exit status
run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== src.f ====
+incdir+src
src/rf_pkg.sv
src/issue_if.sv
src/issue_stage.sv
src/xor_regfile.sv
src/alu_lane.sv
src/writeback_stage.sv
src/exec_core.sv
verif/tb_exec_core.sv

// ==== src/alu_lane.sv ====
`timescale 1ns/1ps
`default_nettype none

// One integer ALU lane
// The lane hands its source indices to two register file read ports and
// computes the result from the operands that come back in the same cycle
module alu_lane import rf_pkg::*; (
    issue_if.issue_dst  lane_i,

    // Operands returned by the register file, already forwarded
    input  wire word_t  opa_i,
    input  wire word_t  opb_i,

    // Source indices towards the register file read ports
    output preg_t       rs1_o,
    output preg_t       rs2_o,

    output word_t       result_o
);

    // Shift amount comes from the low 5 bits of the second operand
    logic [4:0] shamt;

    assign rs1_o = lane_i.src1;
    assign rs2_o = lane_i.src2;

    assign shamt = opb_i[4:0];

    // The result is computed whether or not the lane is valid
    // Writeback qualifies it with the lane valid bit
    always_comb begin
        case (lane_i.op)
            ALU_ADD: result_o = opa_i + opb_i;
            ALU_SUB: result_o = opa_i - opb_i;
            ALU_AND: result_o = opa_i & opb_i;
            ALU_OR:  result_o = opa_i | opb_i;
            ALU_XOR: result_o = opa_i ^ opb_i;
            ALU_SLL: result_o = opa_i << shamt;
            ALU_SRL: result_o = opa_i >> shamt;
            // Signed compare, zero-extended to a full word
            ALU_SLT: result_o = word_t'($signed(opa_i) < $signed(opb_i));
            default: result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/exec_core.sv ====
`timescale 1ns/1ps
`default_nettype none

// Integer execution slice
// Issue registers feed two ALU lanes, which read their operands from the
// XOR-banked register file and return results through the writeback stage
// Issue to result valid is two edges
module exec_core import rf_pkg::*; (
    input  wire logic    clk_i,
    input  wire logic    rst_n_i,

    // Issue lane 0
    input  wire logic    l0_valid_i,
    input  wire alu_op_e l0_op_i,
    input  wire preg_t   l0_src1_i,
    input  wire preg_t   l0_src2_i,
    input  wire preg_t   l0_dest_i,

    // Issue lane 1
    input  wire logic    l1_valid_i,
    input  wire alu_op_e l1_op_i,
    input  wire preg_t   l1_src1_i,
    input  wire preg_t   l1_src2_i,
    input  wire preg_t   l1_dest_i,

    // External write port, visible from the cycle after its edge
    input  wire logic    ext_we_i,
    input  wire preg_t   ext_dest_i,
    input  wire word_t   ext_data_i,

    // External read ports, forwarded like the ALU operand reads
    input  wire preg_t   rd0_src_i,
    input  wire preg_t   rd1_src_i,
    output word_t        rd0_data_o,
    output word_t        rd1_data_o,

    // Registered lane results
    output logic         res0_valid_o,
    output preg_t        res0_dest_o,
    output word_t        res0_data_o,
    output logic         res1_valid_o,
    output preg_t        res1_dest_o,
    output word_t        res1_data_o
);

    // Issued operations, one bundle per lane
    issue_if lane0_if ();
    issue_if lane1_if ();

    // Operand read indices and the operands they return
    preg_t lane0_rs1;
    preg_t lane0_rs2;
    preg_t lane1_rs1;
    preg_t lane1_rs2;
    word_t lane0_opa;
    word_t lane0_opb;
    word_t lane1_opa;
    word_t lane1_opb;

    // Combinational lane results
    word_t lane0_res;
    word_t lane1_res;

    // Writeback registers, shared by the register file and the result ports
    logic  wb0_we;
    preg_t wb0_dest;
    word_t wb0_data;
    logic  wb1_we;
    preg_t wb1_dest;
    word_t wb1_data;

    issue_stage u_issue (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .l0_valid_i (l0_valid_i),
        .l0_op_i    (l0_op_i),
        .l0_src1_i  (l0_src1_i),
        .l0_src2_i  (l0_src2_i),
        .l0_dest_i  (l0_dest_i),
        .l1_valid_i (l1_valid_i),
        .l1_op_i    (l1_op_i),
        .l1_src1_i  (l1_src1_i),
        .l1_src2_i  (l1_src2_i),
        .l1_dest_i  (l1_dest_i),
        .lane0_o    (lane0_if.issue_src),
        .lane1_o    (lane1_if.issue_src)
    );

    // Lane 0 reads through ports 0 and 1, lane 1 through ports 2 and 3
    alu_lane u_alu0 (
        .lane_i   (lane0_if.issue_dst),
        .opa_i    (lane0_opa),
        .opb_i    (lane0_opb),
        .rs1_o    (lane0_rs1),
        .rs2_o    (lane0_rs2),
        .result_o (lane0_res)
    );

    alu_lane u_alu1 (
        .lane_i   (lane1_if.issue_dst),
        .opa_i    (lane1_opa),
        .opb_i    (lane1_opb),
        .rs1_o    (lane1_rs1),
        .rs2_o    (lane1_rs2),
        .result_o (lane1_res)
    );

    // Ports 4 and 5 serve the external reads
    xor_regfile u_regfile (
        .clk_i     (clk_i),
        .w0_we_i   (wb0_we),
        .w0_dest_i (wb0_dest),
        .w0_data_i (wb0_data),
        .w1_we_i   (wb1_we),
        .w1_dest_i (wb1_dest),
        .w1_data_i (wb1_data),
        .w2_we_i   (ext_we_i),
        .w2_dest_i (ext_dest_i),
        .w2_data_i (ext_data_i),
        .r0_src_i  (lane0_rs1),
        .r1_src_i  (lane0_rs2),
        .r2_src_i  (lane1_rs1),
        .r3_src_i  (lane1_rs2),
        .r4_src_i  (rd0_src_i),
        .r5_src_i  (rd1_src_i),
        .r0_data_o (lane0_opa),
        .r1_data_o (lane0_opb),
        .r2_data_o (lane1_opa),
        .r3_data_o (lane1_opb),
        .r4_data_o (rd0_data_o),
        .r5_data_o (rd1_data_o)
    );

    writeback_stage u_writeback (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .lane0_i    (lane0_if.issue_dst),
        .lane1_i    (lane1_if.issue_dst),
        .res0_i     (lane0_res),
        .res1_i     (lane1_res),
        .wb0_we_o   (wb0_we),
        .wb0_dest_o (wb0_dest),
        .wb0_data_o (wb0_data),
        .wb1_we_o   (wb1_we),
        .wb1_dest_o (wb1_dest),
        .wb1_data_o (wb1_data)
    );

    // Result outputs show the writeback registers directly
    assign res0_valid_o = wb0_we;
    assign res0_dest_o  = wb0_dest;
    assign res0_data_o  = wb0_data;
    assign res1_valid_o = wb1_we;
    assign res1_dest_o  = wb1_dest;
    assign res1_data_o  = wb1_data;

endmodule

`default_nettype wire

// ==== src/issue_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// One issued operation as it travels from the issue registers to the execute
// and writeback stages
interface issue_if import rf_pkg::*; ();

    // Qualifies the rest of the bundle for the current cycle
    logic    valid;
    alu_op_e op;
    preg_t   src1;
    preg_t   src2;
    preg_t   dest;

    // The issue stage owns every signal of the bundle
    modport issue_src (
        output valid,
        output op,
        output src1,
        output src2,
        output dest
    );

    // The ALU lane and the writeback stage only observe the operation
    modport issue_dst (
        input valid,
        input op,
        input src1,
        input src2,
        input dest
    );

endinterface

`default_nettype wire

// ==== src/issue_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

// Input side of the execution slice
// Both issue lanes are captured on every rising edge and presented to the
// ALU lanes for exactly one cycle
module issue_stage import rf_pkg::*; (
    input  wire logic    clk_i,
    input  wire logic    rst_n_i,

    // Lane 0 operation from the scheduler
    input  wire logic    l0_valid_i,
    input  wire alu_op_e l0_op_i,
    input  wire preg_t   l0_src1_i,
    input  wire preg_t   l0_src2_i,
    input  wire preg_t   l0_dest_i,

    // Lane 1 operation from the scheduler
    input  wire logic    l1_valid_i,
    input  wire alu_op_e l1_op_i,
    input  wire preg_t   l1_src1_i,
    input  wire preg_t   l1_src2_i,
    input  wire preg_t   l1_dest_i,

    issue_if.issue_src   lane0_o,
    issue_if.issue_src   lane1_o
);

    // Valid bits are the only control state here
    // A new operation replaces the old one each cycle, so there is no hold path
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            lane0_o.valid <= 1'b0;
            lane1_o.valid <= 1'b0;
        end else begin
            lane0_o.valid <= l0_valid_i;
            lane1_o.valid <= l1_valid_i;
        end
    end

    // Operation fields are only loaded for a valid operation
    // An idle lane keeps its last fields, which nobody looks at while valid is low
    always_ff @(posedge clk_i) begin
        if (l0_valid_i) begin
            lane0_o.op   <= l0_op_i;
            lane0_o.src1 <= l0_src1_i;
            lane0_o.src2 <= l0_src2_i;
            lane0_o.dest <= l0_dest_i;
        end
        if (l1_valid_i) begin
            lane1_o.op   <= l1_op_i;
            lane1_o.src1 <= l1_src1_i;
            lane1_o.src2 <= l1_src2_i;
            lane1_o.dest <= l1_dest_i;
        end
    end

    // Two results landing on one register in the same writeback cycle would
    // collide on write ports 0 and 1 two edges later
    a_dual_issue_dest_distinct : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (l0_valid_i && l1_valid_i) |-> (l0_dest_i != l1_dest_i)
    );

    // Lane 1 executes alongside lane 0, so it cannot consume lane 0's result
    // from the same issue group; forwarding only covers the group before
    a_no_intra_group_dependence : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (l0_valid_i && l1_valid_i) |->
            ((l1_src1_i != l0_dest_i) && (l1_src2_i != l0_dest_i))
    );

endmodule

`default_nettype wire

// ==== src/rf_params.svh ====
`ifndef RF_PARAMS_SVH
`define RF_PARAMS_SVH

// Number of physical registers held by every bank of the register file
`define RF_NUM_REGS 64

// Width of one data word on the datapath
`define RF_XLEN 32

// Width of a physical register index, log2 of the register count
`define RF_IDX_W 6

`endif

// ==== src/rf_pkg.sv ====
`default_nettype none

`include "rf_params.svh"

package rf_pkg;

    // One datapath word, as stored in the register file and produced by an ALU
    typedef logic [`RF_XLEN-1:0] word_t;

    // Physical register index used for sources and destinations
    typedef logic [`RF_IDX_W-1:0] preg_t;

    // ALU opcodes carried by an issued operation
    // Shifts take their amount from the low 5 bits of the second operand
    // SLT compares both operands as signed values and yields 1 or 0
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLL = 3'd5,
        ALU_SRL = 3'd6,
        ALU_SLT = 3'd7
    } alu_op_e;

endpackage

`default_nettype wire

// ==== src/writeback_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

// Output side of the execution slice
// Both lane results are registered here, and the registers drive write ports
// 0 and 1 of the register file as well as the result outputs of the core
module writeback_stage import rf_pkg::*; (
    input  wire logic   clk_i,
    input  wire logic   rst_n_i,

    // The operations that produced this cycle's results
    issue_if.issue_dst  lane0_i,
    issue_if.issue_dst  lane1_i,

    // Combinational results from the ALU lanes
    input  wire word_t  res0_i,
    input  wire word_t  res1_i,

    output logic        wb0_we_o,
    output preg_t       wb0_dest_o,
    output word_t       wb0_data_o,

    output logic        wb1_we_o,
    output preg_t       wb1_dest_o,
    output word_t       wb1_data_o
);

    // Write enables double as result valids, so they are the reset state
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wb0_we_o <= 1'b0;
            wb1_we_o <= 1'b0;
        end else begin
            wb0_we_o <= lane0_i.valid;
            wb1_we_o <= lane1_i.valid;
        end
    end

    // Destination and data are captured only for a valid operation
    // With no back-pressure each result is held for exactly one cycle, during
    // which the register file also forwards it to all read ports
    always_ff @(posedge clk_i) begin
        if (lane0_i.valid) begin
            wb0_dest_o <= lane0_i.dest;
            wb0_data_o <= res0_i;
        end
        if (lane1_i.valid) begin
            wb1_dest_o <= lane1_i.dest;
            wb1_data_o <= res1_i;
        end
    end

endmodule

`default_nettype wire

// ==== src/xor_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rf_params.svh"

// Physical register file with three write ports and six read ports
// Each write port owns one bank, and the architectural value of a register is
// the XOR of its three bank entries, which avoids a multi-ported storage cell
module xor_regfile import rf_pkg::*; (
    input  wire logic  clk_i,

    // Write port 0, ALU lane 0 writeback
    input  wire logic  w0_we_i,
    input  wire preg_t w0_dest_i,
    input  wire word_t w0_data_i,

    // Write port 1, ALU lane 1 writeback
    input  wire logic  w1_we_i,
    input  wire preg_t w1_dest_i,
    input  wire word_t w1_data_i,

    // Write port 2, external data such as load returns
    input  wire logic  w2_we_i,
    input  wire preg_t w2_dest_i,
    input  wire word_t w2_data_i,

    // Read ports, all combinational
    input  wire preg_t r0_src_i,
    input  wire preg_t r1_src_i,
    input  wire preg_t r2_src_i,
    input  wire preg_t r3_src_i,
    input  wire preg_t r4_src_i,
    input  wire preg_t r5_src_i,
    output logic  [`RF_XLEN-1:0] r0_data_o,
    output word_t r1_data_o,
    output word_t r2_data_o,
    output word_t r3_data_o,
    output word_t r4_data_o,
    output word_t r5_data_o
);

    localparam int NUM_RD = 6;

    // One bank per write port, no reset on the storage
    word_t bank0 [`RF_NUM_REGS];
    word_t bank1 [`RF_NUM_REGS];
    word_t bank2 [`RF_NUM_REGS];

    // Read ports gathered into arrays so the read logic is written once
    preg_t rd_src  [NUM_RD];
    word_t rd_data [NUM_RD];

    assign rd_src[0] = r0_src_i;
    assign rd_src[1] = r1_src_i;
    assign rd_src[2] = r2_src_i;
    assign rd_src[3] = r3_src_i;
    assign rd_src[4] = r4_src_i;
    assign rd_src[5] = r5_src_i;

    assign r0_data_o = rd_data[0];
    assign r1_data_o = rd_data[1];
    assign r2_data_o = rd_data[2];
    assign r3_data_o = rd_data[3];
    assign r4_data_o = rd_data[4];
    assign r5_data_o = rd_data[5];

    // Every read port sees the ALU writebacks of this cycle before the banks
    // Port 0 takes priority over port 1, although the issue rules keep them apart
    // Port 2 is not forwarded and shows up one cycle after its edge
    for (genvar k = 0; k < NUM_RD; k++) begin : g_read
        logic hit_w0;
        logic hit_w1;

        assign hit_w0 = w0_we_i && (w0_dest_i == rd_src[k]);
        assign hit_w1 = w1_we_i && (w1_dest_i == rd_src[k]);

        assign rd_data[k] = hit_w0 ? w0_data_i :
                            hit_w1 ? w1_data_i :
                            bank0[rd_src[k]] ^ bank1[rd_src[k]] ^ bank2[rd_src[k]];
    end

    // A port stores its data folded with the other two banks at that index,
    // so that the XOR of all three banks gives back the written word
    // The other banks are read at their old contents, which is correct only
    // while no two ports write the same index in one cycle
    always_ff @(posedge clk_i) begin
        if (w0_we_i) begin
            bank0[w0_dest_i] <= w0_data_i ^ bank1[w0_dest_i] ^ bank2[w0_dest_i];
        end
        if (w1_we_i) begin
            bank1[w1_dest_i] <= w1_data_i ^ bank0[w1_dest_i] ^ bank2[w1_dest_i];
        end
        if (w2_we_i) begin
            bank2[w2_dest_i] <= w2_data_i ^ bank0[w2_dest_i] ^ bank1[w2_dest_i];
        end
    end

    // Same-index writes would corrupt the XOR encoding of that register
    // Ports 0 and 1 come from the issue group, port 2 from outside the core
    a_w0_w1_distinct : assert property (
        @(posedge clk_i) (w0_we_i && w1_we_i) |-> (w0_dest_i != w1_dest_i)
    );

    a_w0_w2_distinct : assert property (
        @(posedge clk_i) (w0_we_i && w2_we_i) |-> (w0_dest_i != w2_dest_i)
    );

    a_w1_w2_distinct : assert property (
        @(posedge clk_i) (w1_we_i && w2_we_i) |-> (w1_dest_i != w2_dest_i)
    );

endmodule

`default_nettype wire

// ==== verif/tb_exec_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rf_params.svh"

module tb_exec_core import rf_pkg::*; ();

    // One lane of an issue group
    typedef struct {
        logic    v;
        alu_op_e op;
        preg_t   s1;
        preg_t   s2;
        preg_t   d;
    } lane_op_t;

    // One cycle of stimulus for the whole core
    typedef struct {
        lane_op_t lane [2];
        logic     ext_we;
        preg_t    ext_d;
        word_t    ext_data;
        preg_t    rd [2];
    } stim_t;

    // Expected writeback of one lane
    typedef struct {
        logic  v;
        preg_t d;
        word_t data;
    } wb_t;

    localparam int INIT_STEPS = `RF_NUM_REGS;
    localparam int RAND_STEPS = 100;
    localparam int READBACK_STEPS = `RF_NUM_REGS + 1;

    logic    clk;
    logic    rst_n;
    logic    l0_valid;
    logic    l1_valid;
    alu_op_e l0_op;
    alu_op_e l1_op;
    preg_t   l0_src1;
    preg_t   l0_src2;
    preg_t   l0_dest;
    preg_t   l1_src1;
    preg_t   l1_src2;
    preg_t   l1_dest;
    logic    ext_we;
    preg_t   ext_dest;
    word_t   ext_data;
    preg_t   rd0_src;
    preg_t   rd1_src;
    word_t   rd0_data;
    word_t   rd1_data;
    logic    res0_valid;
    logic    res1_valid;
    preg_t   res0_dest;
    preg_t   res1_dest;
    word_t   res0_data;
    word_t   res1_data;

    // Reference register file and the groups still in the pipeline
    word_t   model [`RF_NUM_REGS];
    bit      known [`RF_NUM_REGS];
    wb_t     prev1 [2];
    wb_t     prev2 [2];
    stim_t   table_q [$];
    stim_t   cur_e;
    integer  seed = 32'h2bfb_177e;

    exec_core dut0 (
        .clk_i (clk), .rst_n_i (rst_n),
        .l0_valid_i (l0_valid), .l0_op_i (l0_op), .l0_src1_i (l0_src1),
        .l0_src2_i (l0_src2), .l0_dest_i (l0_dest),
        .l1_valid_i (l1_valid), .l1_op_i (l1_op), .l1_src1_i (l1_src1),
        .l1_src2_i (l1_src2), .l1_dest_i (l1_dest),
        .ext_we_i (ext_we), .ext_dest_i (ext_dest), .ext_data_i (ext_data),
        .rd0_src_i (rd0_src), .rd1_src_i (rd1_src),
        .rd0_data_o (rd0_data), .rd1_data_o (rd1_data),
        .res0_valid_o (res0_valid), .res0_dest_o (res0_dest), .res0_data_o (res0_data),
        .res1_valid_o (res1_valid), .res1_dest_o (res1_dest), .res1_data_o (res1_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_on_error();
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("FAIL time=%0t %s got=%h expected=%h", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_preg(input string name, input preg_t got, input preg_t exp);
        if (got !== exp) begin
            $display("FAIL time=%0t %s got=%0d expected=%0d", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_valid(input string name, input bit got, input bit exp);
        if (got !== exp) begin
            $display("FAIL time=%0t %s got=%0b expected=%0b", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    // ALU behavior as the opcode list defines it
    function automatic word_t alu_ref(input alu_op_e op, input word_t a, input word_t b);
        case (op)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLL: return a << b[4:0];
            ALU_SRL: return a >> b[4:0];
            default: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        endcase
    endfunction

    // A read sees the given writeback group first, lane 0 ahead of lane 1
    function automatic bit lookup(input wb_t wb [2], input preg_t src, output word_t val);
        for (int k = 0; k < 2; k++) begin
            if (wb[k].v && wb[k].d == src) begin
                val = wb[k].data;
                return 1'b1;
            end
        end
        val = model[src];
        return known[src];
    endfunction

    // External reads compare against the group sitting in writeback right now
    task automatic check_reads();
        word_t exp;
        if (lookup(prev2, rd0_src, exp)) check_word("rd0_data_o", rd0_data, exp);
        if (lookup(prev2, rd1_src, exp)) check_word("rd1_data_o", rd1_data, exp);
    endtask

    task automatic apply_step(input stim_t e);
        wb_t   now [2];
        word_t a;
        word_t b;
        @(negedge clk);
        // Group issued two edges ago is on the result ports in this cycle
        check_valid("res0_valid_o", res0_valid, prev2[0].v);
        check_valid("res1_valid_o", res1_valid, prev2[1].v);
        if (prev2[0].v) begin
            check_preg("res0_dest_o", res0_dest, prev2[0].d);
            check_word("res0_data_o", res0_data, prev2[0].data);
        end
        if (prev2[1].v) begin
            check_preg("res1_dest_o", res1_dest, prev2[1].d);
            check_word("res1_data_o", res1_data, prev2[1].data);
        end
        check_reads();
        l0_valid = e.lane[0].v;
        l0_op    = e.lane[0].op;
        l0_src1  = e.lane[0].s1;
        l0_src2  = e.lane[0].s2;
        l0_dest  = e.lane[0].d;
        l1_valid = e.lane[1].v;
        l1_op    = e.lane[1].op;
        l1_src1  = e.lane[1].s1;
        l1_src2  = e.lane[1].s2;
        l1_dest  = e.lane[1].d;
        ext_we   = e.ext_we;
        ext_dest = e.ext_d;
        ext_data = e.ext_data;
        rd0_src  = e.rd[0];
        rd1_src  = e.rd[1];
        // An ext write driven now is not visible yet
        #1;
        check_reads();
        // Next edge commits the writeback group and the ext write
        for (int k = 0; k < 2; k++) begin
            if (prev2[k].v) begin
                model[prev2[k].d] = prev2[k].data;
                known[prev2[k].d] = 1'b1;
            end
        end
        if (e.ext_we) begin
            model[e.ext_d] = e.ext_data;
            known[e.ext_d] = 1'b1;
        end
        // Operands come from the file after that edge, or from the group before
        for (int k = 0; k < 2; k++) begin
            void'(lookup(prev1, e.lane[k].s1, a));
            void'(lookup(prev1, e.lane[k].s2, b));
            now[k].v    = e.lane[k].v;
            now[k].d    = e.lane[k].d;
            now[k].data = alu_ref(e.lane[k].op, a, b);
        end
        prev2 = prev1;
        prev1 = now;
    endtask

    task automatic new_entry();
        for (int k = 0; k < 2; k++) begin
            cur_e.lane[k] = '{1'b0, ALU_ADD, '0, '0, '0};
            cur_e.rd[k]   = '0;
        end
        cur_e.ext_we   = 1'b0;
        cur_e.ext_d    = '0;
        cur_e.ext_data = '0;
    endtask

    task automatic lane_op(input int k, input alu_op_e op, input int s1, input int s2,
                           input int d);
        cur_e.lane[k] = '{1'b1, op, preg_t'(s1), preg_t'(s2), preg_t'(d)};
    endtask

    task automatic read_at(input int a, input int b);
        cur_e.rd[0] = preg_t'(a);
        cur_e.rd[1] = preg_t'(b);
    endtask

    task automatic ext_write(input int d, input word_t data);
        cur_e.ext_we   = 1'b1;
        cur_e.ext_d    = preg_t'(d);
        cur_e.ext_data = data;
    endtask

    // Random dual issue that keeps to the issue rules
    task automatic random_entry();
        new_entry();
        lane_op(0, alu_op_e'(3'($random(seed))), preg_t'($random(seed)),
                preg_t'($random(seed)), preg_t'($random(seed)));
        cur_e.lane[1] = '{1'b1, alu_op_e'(3'($random(seed))), preg_t'($random(seed)),
                          preg_t'($random(seed)), preg_t'($random(seed))};
        while (cur_e.lane[1].d == cur_e.lane[0].d) cur_e.lane[1].d = preg_t'($random(seed));
        while (cur_e.lane[1].s1 == cur_e.lane[0].d) cur_e.lane[1].s1 = preg_t'($random(seed));
        while (cur_e.lane[1].s2 == cur_e.lane[0].d) cur_e.lane[1].s2 = preg_t'($random(seed));
        if (($random(seed) & 3) == 0) begin
            ext_write(preg_t'($random(seed)), word_t'($random(seed)));
            // The group in writeback at the ext edge was issued two steps back
            while ((prev2[0].v && cur_e.ext_d == prev2[0].d) ||
                   (prev2[1].v && cur_e.ext_d == prev2[1].d)) begin
                cur_e.ext_d = preg_t'($random(seed));
            end
        end
        read_at(preg_t'($random(seed)), preg_t'($random(seed)));
    endtask

    initial begin
        longint limit;
        #1;
        limit = table_q.size() + INIT_STEPS + RAND_STEPS + READBACK_STEPS + 20;
        #(limit * 100);
        $display("Timeout: the testbench did not reach its end in time");
        $display("SOME TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        rst_n = 1'b0;
        new_entry();
        // Both lanes offer operations during reset, which the cleared valids must hide
        l0_valid = 1'b1;
        l1_valid = 1'b1;
        ext_we   = 1'b0;
        l0_op    = ALU_ADD;
        l1_op    = ALU_ADD;
        {l0_src1, l0_src2, l0_dest, l1_src1, l1_src2} = '0;
        l1_dest  = preg_t'(1);
        {ext_dest, ext_data, rd0_src, rd1_src} = '0;
        prev1 = '{default: '{1'b0, 6'd0, 32'd0}};
        prev2 = prev1;
        // Fixed cases: ext write visibility, every opcode on each lane, forwarding
        new_entry();
        ext_write(10, 32'h1234_5678);
        read_at(10, 10);
        table_q.push_back(cur_e);
        new_entry();
        ext_write(11, 32'h8000_0001);
        read_at(10, 11);
        table_q.push_back(cur_e);
        new_entry();
        read_at(11, 11);
        table_q.push_back(cur_e);
        for (int k = 0; k < 8; k++) begin
            new_entry();
            lane_op(0, alu_op_e'(k), 1, 10, 20 + k);
            lane_op(1, alu_op_e'(7 - k), 11, 2, 30 + k);
            read_at(18 + k, 28 + k);
            table_q.push_back(cur_e);
        end
        new_entry();
        lane_op(0, ALU_ADD, 1, 2, 40);
        lane_op(1, ALU_SUB, 3, 4, 41);
        read_at(26, 36);
        table_q.push_back(cur_e);
        new_entry();
        lane_op(0, ALU_XOR, 40, 41, 42);
        lane_op(1, ALU_ADD, 41, 40, 43);
        read_at(27, 37);
        table_q.push_back(cur_e);
        new_entry();
        lane_op(0, ALU_SLT, 43, 42, 44);
        lane_op(1, ALU_SLL, 42, 43, 45);
        read_at(40, 41);
        table_q.push_back(cur_e);
        new_entry();
        lane_op(0, ALU_SUB, 44, 45, 46);
        lane_op(1, ALU_SRL, 45, 44, 47);
        read_at(42, 43);
        table_q.push_back(cur_e);
        new_entry();
        read_at(44, 45);
        table_q.push_back(cur_e);
        new_entry();
        read_at(46, 47);
        table_q.push_back(cur_e);
        new_entry();
        read_at(46, 47);
        table_q.push_back(cur_e);

        // Result valids stay low through reset
        repeat (2) begin
            @(negedge clk);
            check_valid("res0_valid_o", res0_valid, 1'b0);
            check_valid("res1_valid_o", res1_valid, 1'b0);
        end
        rst_n = 1'b1;
        l0_valid = 1'b0;
        l1_valid = 1'b0;

        // Every register gets a defined value before any ALU use
        for (int i = 0; i < INIT_STEPS; i++) begin
            new_entry();
            ext_write(i, word_t'($random(seed)));
            read_at(i, (i + 63) % 64);
            apply_step(cur_e);
        end
        foreach (table_q[i]) apply_step(table_q[i]);
        repeat (RAND_STEPS) begin
            random_entry();
            apply_step(cur_e);
        end
        // Idle cycles drain the pipeline while every register is read back
        for (int i = 0; i < READBACK_STEPS; i++) begin
            new_entry();
            read_at(i % 64, 63 - (i % 64));
            apply_step(cur_e);
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire
